// ==== ext_subsys.f ====
rtl/ext_subsys_pkg.sv
rtl/delay_line.sv
rtl/slow_mem.sv
rtl/obi_mem_demux.sv
rtl/pwr_ctrl_regs.sv
rtl/ext_subsys.sv
verif/ext_subsys_chk.sv
verif/tb_ext_subsys.sv

// ==== rtl/delay_line.sv ====
/*
 * Fixed-depth shift register over any payload type, with reset value
 */
`default_nettype none

module delay_line #(
  parameter type T = logic,
  parameter int unsigned DEPTH = 1,
  parameter T RESET_VAL = '0
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  T     d_i,
  output T     q_o
);

  T stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= RESET_VAL;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== rtl/ext_subsys.sv ====
/*
 * External subsystem top: two slow memories behind an OBI decoder,
 * power control registers and the switch cell model
 */
`default_nettype none

module ext_subsys (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  ext_subsys_pkg::obi_req_t    mem_req_i,
  output ext_subsys_pkg::obi_rsp_t    mem_rsp_o,
  input  ext_subsys_pkg::reg_req_t    reg_req_i,
  output ext_subsys_pkg::reg_rsp_t    reg_rsp_o,
  output ext_subsys_pkg::domain_vec_t switch_n_o,
  output logic                        irq_o
);

  ext_subsys_pkg::obi_req_t    mem0_req;
  ext_subsys_pkg::obi_req_t    mem1_req;
  ext_subsys_pkg::obi_rsp_t    mem0_rsp;
  ext_subsys_pkg::obi_rsp_t    mem1_rsp;
  ext_subsys_pkg::domain_vec_t switch_ack_n;

  obi_mem_demux u_obi_mem_demux (
    .req_i     (mem_req_i),
    .rsp_o     (mem_rsp_o),
    .mem0_req_o(mem0_req),
    .mem1_req_o(mem1_req),
    .mem0_rsp_i(mem0_rsp),
    .mem1_rsp_i(mem1_rsp)
  );

  slow_mem u_slow_mem0 (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (mem0_req),
    .rsp_o   (mem0_rsp)
  );

  slow_mem u_slow_mem1 (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (mem1_req),
    .rsp_o   (mem1_rsp)
  );

  pwr_ctrl_regs u_pwr_ctrl_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .switch_n_o    (switch_n_o),
    .switch_ack_n_i(switch_ack_n),
    .irq_o         (irq_o)
  );

  // Switch cells, all domains powered out of reset
  delay_line #(
    .T        (ext_subsys_pkg::domain_vec_t),
    .DEPTH    (ext_subsys_pkg::SWITCH_ACK_LATENCY),
    .RESET_VAL('1)
  ) u_switch_cells (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .d_i     (switch_n_o),
    .q_o     (switch_ack_n)
  );

endmodule

`default_nettype wire

// ==== rtl/ext_subsys_pkg.sv ====
/*
 * Shared types and constants of the external subsystem: OBI and register
 * bus structs, register offsets, memory map, latencies
 */
`default_nettype none

package ext_subsys_pkg;

  localparam int unsigned NUM_DOMAINS = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  localparam int unsigned MEM_LATENCY = 3;
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_IDX_W = 8;

  // Second memory region, 0x400 to 0x7FF
  localparam logic [31:0] SLOW_MEM1_BASE = 32'h0000_0400;
  localparam logic [31:0] SLOW_MEM1_MASK = 32'hFFFF_FC00;

  // Power control register offsets
  localparam logic [31:0] REG_SWITCH = 32'h0;
  localparam logic [31:0] REG_ACK = 32'h4;
  localparam logic [31:0] REG_IRQ_PENDING = 32'h8;
  localparam logic [31:0] REG_IRQ_ENABLE = 32'hC;

  typedef logic [NUM_DOMAINS-1:0] domain_vec_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  // Payload carried by the memory read pipeline
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/obi_mem_demux.sv ====
/*
 * OBI address decoder for two memories, first memory as default target
 */
`default_nettype none

module obi_mem_demux (
  input  ext_subsys_pkg::obi_req_t req_i,
  output ext_subsys_pkg::obi_rsp_t rsp_o,
  output ext_subsys_pkg::obi_req_t mem0_req_o,
  output ext_subsys_pkg::obi_req_t mem1_req_o,
  input  ext_subsys_pkg::obi_rsp_t mem0_rsp_i,
  input  ext_subsys_pkg::obi_rsp_t mem1_rsp_i
);

  logic sel_mem1;

  assign sel_mem1 = (req_i.addr & ext_subsys_pkg::SLOW_MEM1_MASK)
                    == ext_subsys_pkg::SLOW_MEM1_BASE;

  always_comb begin
    mem0_req_o     = req_i;
    mem1_req_o     = req_i;
    mem0_req_o.req = req_i.req & ~sel_mem1;
    mem1_req_o.req = req_i.req & sel_mem1;
  end

  assign rsp_o.gnt = sel_mem1 ? mem1_rsp_i.gnt : mem0_rsp_i.gnt;

  // Same latency on both sides, so at most one rvalid per cycle
  assign rsp_o.rvalid = mem0_rsp_i.rvalid | mem1_rsp_i.rvalid;
  assign rsp_o.rdata  = mem1_rsp_i.rvalid ? mem1_rsp_i.rdata : mem0_rsp_i.rdata;

endmodule

`default_nettype wire

// ==== rtl/pwr_ctrl_regs.sv ====
/*
 * Power control registers: switch request, acknowledge readback,
 * interrupt pending and enable, completion interrupt
 */
`default_nettype none

module pwr_ctrl_regs (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  ext_subsys_pkg::reg_req_t    reg_req_i,
  output ext_subsys_pkg::reg_rsp_t    reg_rsp_o,
  output ext_subsys_pkg::domain_vec_t switch_n_o,
  input  ext_subsys_pkg::domain_vec_t switch_ack_n_i,
  output logic                        irq_o
);

  ext_subsys_pkg::domain_vec_t switch_q;
  ext_subsys_pkg::domain_vec_t ack_q;
  ext_subsys_pkg::domain_vec_t pending_q;
  ext_subsys_pkg::domain_vec_t enable_q;
  ext_subsys_pkg::domain_vec_t ack_chg;
  ext_subsys_pkg::domain_vec_t pend_clr;
  logic                        irq_q;

  logic hit_switch, hit_ack, hit_pending, hit_enable;
  logic wr;

  assign hit_switch  = reg_req_i.addr == ext_subsys_pkg::REG_SWITCH;
  assign hit_ack     = reg_req_i.addr == ext_subsys_pkg::REG_ACK;
  assign hit_pending = reg_req_i.addr == ext_subsys_pkg::REG_IRQ_PENDING;
  assign hit_enable  = reg_req_i.addr == ext_subsys_pkg::REG_IRQ_ENABLE;

  assign wr = reg_req_i.valid & reg_req_i.write;

  assign ack_chg  = switch_ack_n_i ^ ack_q;
  assign pend_clr = (wr && hit_pending) ?
                    reg_req_i.wdata[ext_subsys_pkg::NUM_DOMAINS-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_q  <= '1;
      ack_q     <= '1;
      pending_q <= '0;
      enable_q  <= '0;
      irq_q     <= 1'b0;
    end else begin
      ack_q <= switch_ack_n_i;
      if (wr && hit_switch) begin
        switch_q <= reg_req_i.wdata[ext_subsys_pkg::NUM_DOMAINS-1:0];
      end
      if (wr && hit_enable) begin
        enable_q <= reg_req_i.wdata[ext_subsys_pkg::NUM_DOMAINS-1:0];
      end
      // A new acknowledge edge beats a software clear
      pending_q <= (pending_q & ~pend_clr) | ack_chg;
      irq_q     <= |(pending_q & enable_q);
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid & ~(hit_switch | hit_ack | hit_pending | hit_enable);
    reg_rsp_o.rdata = '0;
    if (hit_switch) reg_rsp_o.rdata[ext_subsys_pkg::NUM_DOMAINS-1:0] = switch_q;
    if (hit_ack) reg_rsp_o.rdata[ext_subsys_pkg::NUM_DOMAINS-1:0] = switch_ack_n_i;
    if (hit_pending) reg_rsp_o.rdata[ext_subsys_pkg::NUM_DOMAINS-1:0] = pending_q;
    if (hit_enable) reg_rsp_o.rdata[ext_subsys_pkg::NUM_DOMAINS-1:0] = enable_q;
  end

  assign switch_n_o = switch_q;
  assign irq_o      = irq_q;

endmodule

`default_nettype wire

// ==== rtl/slow_mem.sv ====
/*
 * Word memory on OBI with byte-enabled writes; grants at once and
 * returns read data after a fixed latency
 */
`default_nettype none

module slow_mem (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  ext_subsys_pkg::obi_req_t req_i,
  output ext_subsys_pkg::obi_rsp_t rsp_o
);

  logic [31:0] mem_q [ext_subsys_pkg::MEM_WORDS];

  logic [ext_subsys_pkg::MEM_IDX_W-1:0] idx;
  logic                                 accept_wr;
  logic                                 accept_rd;

  ext_subsys_pkg::mem_resp_t rd_d;
  ext_subsys_pkg::mem_resp_t rd_q;

  // Word index wraps at MEM_WORDS
  assign idx = req_i.addr[ext_subsys_pkg::MEM_IDX_W+1:2];

  assign accept_wr = req_i.req & req_i.we;
  assign accept_rd = req_i.req & ~req_i.we;

  always_ff @(posedge clk_i) begin
    if (accept_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Word is sampled at the accepting edge, then travels down the pipe
  assign rd_d.rvalid = accept_rd;
  assign rd_d.rdata  = mem_q[idx];

  delay_line #(
    .T        (ext_subsys_pkg::mem_resp_t),
    .DEPTH    (ext_subsys_pkg::MEM_LATENCY),
    .RESET_VAL('0)
  ) u_rsp_delay (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .d_i     (rd_d),
    .q_o     (rd_q)
  );

  // No wait states
  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rd_q.rvalid;
  assign rsp_o.rdata  = rd_q.rdata;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ext_subsys -f ext_subsys.f &&
./obj_dir/Vtb_ext_subsys +verilator+error+limit+100 | tee /dev/stderr |
  grep -x "Everything OK" > /dev/null &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== verif/ext_subsys_chk.sv ====
/*
 * Concurrent timing checks on the ext_subsys ports, bound into the top level
 */
`default_nettype none

module ext_subsys_chk (
  input logic                        clk_i,
  input logic                        arst_n_i,
  input ext_subsys_pkg::obi_req_t    mem_req_i,
  input ext_subsys_pkg::obi_rsp_t    mem_rsp_i,
  input ext_subsys_pkg::reg_req_t    reg_req_i,
  input ext_subsys_pkg::reg_rsp_t    reg_rsp_i,
  input ext_subsys_pkg::domain_vec_t switch_n_i
);

  int   fail_cnt = 0;
  logic rd_accept;

  assign rd_accept = mem_req_i.req & mem_rsp_i.gnt & ~mem_req_i.we;

  // No wait states on OBI
  a_gnt_eq_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rsp_i.gnt == mem_req_i.req)
    else begin $error("OBI grant differs from request"); fail_cnt++; end

  // Read data comes back a fixed number of edges after acceptance
  a_rd_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rsp_i.rvalid == $past(rd_accept, ext_subsys_pkg::MEM_LATENCY))
    else begin $error("OBI response valid off its fixed latency"); fail_cnt++; end

  a_ready_eq_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reg_rsp_i.ready == reg_req_i.valid)
    else begin $error("Register ready differs from valid"); fail_cnt++; end

  // All domains powered when reset lifts
  a_switch_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> switch_n_i == '1)
    else begin $error("Switch request not all ones after reset"); fail_cnt++; end

endmodule

bind ext_subsys ext_subsys_chk u_chk (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .mem_req_i (mem_req_i),
  .mem_rsp_i (mem_rsp_o),
  .reg_req_i (reg_req_i),
  .reg_rsp_i (reg_rsp_o),
  .switch_n_i(switch_n_o)
);

`default_nettype wire

// ==== verif/tb_ext_subsys.sv ====
/*
 * Testbench for ext_subsys: clock, reset, OBI and register stimulus,
 * reference memory model and per-test reporting
 */
`default_nettype none

module tb_ext_subsys;

  logic                        clk;
  logic                        arst_n;
  ext_subsys_pkg::obi_req_t    mem_req;
  ext_subsys_pkg::obi_rsp_t    mem_rsp;
  ext_subsys_pkg::reg_req_t    reg_req;
  ext_subsys_pkg::reg_rsp_t    reg_rsp;
  ext_subsys_pkg::domain_vec_t switch_n;
  logic                        irq;

  // Reference memory keyed by target memory and word index
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] exp_rd [$];
  logic [31:0] addrs [16];
  logic [31:0] rnd;
  logic [31:0] rdata;
  logic        err;
  int          seed = 30;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          errors_at_start = 0;

  ext_subsys u_dut (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp),
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp),
    .switch_n_o(switch_n),
    .irq_o     (irq)
  );

  always #10 clk = ~clk;

  // Region 0x400..0x7FF is the second memory, all else the first
  function automatic logic [31:0] mem_key(input logic [31:0] addr);
    logic in_mem1;
    in_mem1 = (addr >= 32'h400) && (addr <= 32'h7FF);
    return {23'h0, in_mem1, addr[9:2]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
      $display("PASS  %s", name);
    end else begin
      failed++;
      $display("FAIL  %s", name);
    end
    errors_at_start = errors;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] key;
    key = mem_key(addr);
    ref_mem[key] = merge_bytes(ref_mem.exists(key) ? ref_mem[key] : 32'h0, data, be);
    @(posedge clk);
    mem_req <= '{req: 1'b1, we: 1'b1, be: be, addr: addr, wdata: data};
  endtask

  task automatic obi_read(input logic [31:0] addr);
    exp_rd.push_back(ref_mem[mem_key(addr)]);
    @(posedge clk);
    mem_req <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: addr, wdata: 32'h0};
  endtask

  task automatic obi_idle_drain();
    int n;
    n = 0;
    @(posedge clk);
    mem_req <= '0;
    while (exp_rd.size() != 0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (exp_rd.size() != 0) begin
      $display("Timeout: %0d read responses never arrived", exp_rd.size());
      errors++;
      exp_rd.delete();
    end
  endtask

  // Responses must come back in issue order
  always @(negedge clk) begin
    if (mem_rsp.rvalid) begin
      if (exp_rd.size() == 0) begin
        $display("Read response arrived with no read outstanding");
        errors++;
      end else begin
        check_val("mem_rsp_o.rdata", mem_rsp.rdata, exp_rd.pop_front());
      end
    end
  end

  task automatic reg_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic rd_err);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    @(negedge clk);
    rd = reg_rsp.rdata;
    rd_err = reg_rsp.error;
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic reg_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        rd_err;
    reg_access(1'b0, addr, 32'h0, rd, rd_err);
    check_val(name, rd, exp);
    check_val("reg_rsp_o.error", {31'h0, rd_err}, 32'h0);
  endtask

  // Holds a read on the bus until the value shows up
  task automatic poll_reg(input logic [31:0] addr, input logic [31:0] exp, input int max);
    int n;
    n = 0;
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
    @(negedge clk);
    while (reg_rsp.rdata !== exp && n < max) begin
      @(negedge clk);
      n++;
    end
    if (reg_rsp.rdata !== exp) begin
      $display("Timeout: register %h did not reach %h", addr, exp);
      errors++;
    end
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic wait_irq(input logic level, input int max);
    int n;
    n = 0;
    @(negedge clk);
    while (irq !== level && n < max) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      $display("Timeout: irq_o never went to %0d", level);
      errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    arst_n <= 1'b0;
    mem_req <= '0;
    reg_req <= '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    check_val("switch_n_o", {28'h0, switch_n}, 32'hF);
    check_val("irq_o", {31'h0, irq}, 32'h0);
    reg_expect("REG_ACK", ext_subsys_pkg::REG_ACK, 32'hF);
    reg_expect("REG_IRQ_PENDING", ext_subsys_pkg::REG_IRQ_PENDING, 32'h0);
    reg_expect("REG_IRQ_ENABLE", ext_subsys_pkg::REG_IRQ_ENABLE, 32'h0);
    end_test("reset values");

    // Full word first so partial writes merge into known data
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      addrs[i] = {22'h0, rnd[7:0], 2'b00} | ((i >= 8) ? 32'h400 : 32'h0);
      obi_write(addrs[i], $random(seed), 4'hF);
      rnd = $random(seed);
      obi_write(addrs[i], $random(seed), rnd[3:0]);
    end
    for (int i = 0; i < 16; i++) begin
      obi_read(addrs[i]);
    end
    obi_idle_drain();
    end_test("random byte-enable writes, back-to-back reads");

    obi_write(32'h2084, 32'hCAFE_0001, 4'hF);
    obi_write(32'h484, 32'h0BAD_0002, 4'hF);
    obi_write(32'h84, 32'h1234_5678, 4'b0011);
    obi_read(32'h84);
    obi_read(32'h2084);
    obi_read(32'h1484);
    obi_read(32'h484);
    obi_idle_drain();
    end_test("default target aliasing");

    reg_access(1'b1, ext_subsys_pkg::REG_SWITCH, 32'hA, rdata, err);
    @(negedge clk);
    check_val("switch_n_o", {28'h0, switch_n}, 32'hA);
    poll_reg(ext_subsys_pkg::REG_ACK, 32'hA, ext_subsys_pkg::SWITCH_ACK_LATENCY + 2);
    reg_expect("REG_IRQ_PENDING", ext_subsys_pkg::REG_IRQ_PENDING, 32'h5);
    end_test("switch request and acknowledge");

    reg_access(1'b1, ext_subsys_pkg::REG_IRQ_PENDING, 32'hF, rdata, err);
    reg_access(1'b1, ext_subsys_pkg::REG_IRQ_ENABLE, 32'h1, rdata, err);
    // irq_o sees the new enable one edge later
    repeat (2) @(negedge clk);
    check_val("irq_o", {31'h0, irq}, 32'h0);
    reg_access(1'b1, ext_subsys_pkg::REG_SWITCH, 32'hB, rdata, err);
    wait_irq(1'b1, 25);
    reg_expect("REG_IRQ_PENDING", ext_subsys_pkg::REG_IRQ_PENDING, 32'h1);
    reg_access(1'b1, ext_subsys_pkg::REG_IRQ_PENDING, 32'h1, rdata, err);
    wait_irq(1'b0, 4);
    // Domain 2 is masked
    reg_access(1'b1, ext_subsys_pkg::REG_SWITCH, 32'hF, rdata, err);
    poll_reg(ext_subsys_pkg::REG_ACK, 32'hF, ext_subsys_pkg::SWITCH_ACK_LATENCY + 2);
    reg_expect("REG_IRQ_PENDING", ext_subsys_pkg::REG_IRQ_PENDING, 32'h4);
    repeat (2) @(negedge clk);
    check_val("irq_o", {31'h0, irq}, 32'h0);
    end_test("completion interrupt, clear and mask");

    reg_access(1'b1, 32'h10, 32'h0, rdata, err);
    check_val("reg_rsp_o.error", {31'h0, err}, 32'h1);
    reg_access(1'b0, 32'h10, 32'h0, rdata, err);
    check_val("reg_rsp_o.error", {31'h0, err}, 32'h1);
    reg_expect("REG_SWITCH", ext_subsys_pkg::REG_SWITCH, 32'hF);
    reg_expect("REG_IRQ_ENABLE", ext_subsys_pkg::REG_IRQ_ENABLE, 32'h1);
    end_test("unmapped register offset");

    errors += u_dut.u_chk.fail_cnt;
    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
